// File: logic/rv_decode_pkg.sv
//****************************************************************************
// Shared widths, RV32I opcode and funct encodings, and the select enums
// used by the decode stage. Modules import it inside their body.
//****************************************************************************
`default_nettype none

package rv_decode_pkg;

  localparam int xlen = 32;

  typedef logic [31:0]     instr_t;
  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  // alu funct3, shared by OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000; // sub, sra, srai

  // branch funct3
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_blt     = 3'b100;
  localparam logic [2:0] f3_bge     = 3'b101;
  localparam logic [2:0] f3_bltu    = 3'b110;
  localparam logic [2:0] f3_bgeu    = 3'b111;
  localparam logic [2:0] f3_jalr    = 3'b000;

  // memory funct3, low two bits give the access size
  localparam logic [2:0] f3_lb      = 3'b000;
  localparam logic [2:0] f3_lh      = 3'b001;
  localparam logic [2:0] f3_lw      = 3'b010;
  localparam logic [2:0] f3_lbu     = 3'b100;
  localparam logic [2:0] f3_lhu     = 3'b101;
  localparam logic [2:0] f3_sb      = 3'b000;
  localparam logic [2:0] f3_sh      = 3'b001;
  localparam logic [2:0] f3_sw      = 3'b010;

  typedef enum logic [2:0] {
    fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } instr_fmt_e;

  typedef enum logic [3:0] {
    alu_nop, alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_cpb
  } alu_op_e;

  typedef enum logic [1:0] {
    opa_none, opa_rf, opa_pc
  } opa_sel_e;

  typedef enum logic [1:0] {
    opb_none, opb_rf, opb_imm
  } opb_sel_e;

  typedef enum logic [3:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr
  } br_sel_e;

  typedef enum logic [1:0] {
    wb_none, wb_alu, wb_pc, wb_dmem
  } wb_sel_e;

  typedef enum logic [1:0] {
    be_none, be_byte, be_half, be_word
  } be_sel_e;

endpackage

`default_nettype wire

// File: logic/rv_opcode_decoder.sv
//****************************************************************************
// Combinational RV32I control decoder. Any encoding outside the base set
// raises o_illegal and leaves every control at none/zero.
//****************************************************************************
`default_nettype none

module rv_opcode_decoder (
  input  wire rv_decode_pkg::instr_t i_instr,
  output rv_decode_pkg::instr_fmt_e  o_fmt,
  output rv_decode_pkg::alu_op_e     o_alu_op,
  output rv_decode_pkg::opa_sel_e    o_opa_sel,
  output rv_decode_pkg::opb_sel_e    o_opb_sel,
  output rv_decode_pkg::br_sel_e     o_br_sel,
  output rv_decode_pkg::wb_sel_e     o_wb_sel,
  output rv_decode_pkg::be_sel_e     o_be_sel,
  output logic                       o_rs2_used,
  output logic                       o_dmem_rd,
  output logic                       o_dmem_wr,
  output logic                       o_dmem_sext,
  output logic                       o_en_wb,
  output logic                       o_cond_branch,
  output logic                       o_jump_reg,
  output logic                       o_illegal
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  function automatic alu_op_e alu_of_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      f3_add_sub: op = alt ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    o_fmt       = fmt_r;
    o_alu_op    = alu_nop;
    o_opa_sel   = opa_none;
    o_opb_sel   = opb_none;
    o_br_sel    = br_none;
    o_wb_sel    = wb_none;
    o_be_sel    = be_none;
    o_rs2_used  = 1'b0;
    o_dmem_rd   = 1'b0;
    o_dmem_wr   = 1'b0;
    o_dmem_sext = 1'b0;
    o_illegal   = 1'b0;
    case (opcode)
      opc_op: begin
        if (funct7 == f7_base ||
            (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra))) begin
          o_alu_op   = alu_of_funct(funct3, funct7[5]);
          o_opa_sel  = opa_rf;
          o_opb_sel  = opb_rf;
          o_wb_sel   = wb_alu;
          o_rs2_used = 1'b1;
        end else begin
          o_illegal = 1'b1;
        end
      end
      opc_op_imm: begin
        if ((funct3 == f3_sll && funct7 != f7_base) ||
            (funct3 == f3_srl_sra && funct7 != f7_base && funct7 != f7_alt)) begin
          o_illegal = 1'b1; // bad shift funct7
        end else begin
          o_fmt     = fmt_i;
          o_alu_op  = alu_of_funct(funct3, funct3 == f3_srl_sra && funct7 == f7_alt);
          o_opa_sel = opa_rf;
          o_opb_sel = opb_imm;
          o_wb_sel  = wb_alu;
        end
      end
      opc_lui, opc_auipc: begin
        o_fmt     = fmt_u;
        o_alu_op  = (opcode == opc_lui) ? alu_cpb : alu_add;
        o_opa_sel = (opcode == opc_lui) ? opa_rf : opa_pc;
        o_opb_sel = opb_imm;
        o_wb_sel  = wb_alu;
      end
      opc_branch: begin
        case (funct3)
          f3_beq:  o_br_sel = br_beq;
          f3_bne:  o_br_sel = br_bne;
          f3_blt:  o_br_sel = br_blt;
          f3_bge:  o_br_sel = br_bge;
          f3_bltu: o_br_sel = br_bltu;
          f3_bgeu: o_br_sel = br_bgeu;
          default: o_illegal = 1'b1;
        endcase
        if (o_br_sel != br_none) begin
          o_fmt      = fmt_b;
          o_alu_op   = alu_add; // compare path
          o_opa_sel  = opa_rf;
          o_opb_sel  = opb_rf;
          o_rs2_used = 1'b1;
        end
      end
      opc_jal: begin
        o_fmt    = fmt_j;
        o_br_sel = br_jal;
        o_wb_sel = wb_pc;         // link address
      end
      opc_jalr: begin
        if (funct3 == f3_jalr) begin
          o_fmt     = fmt_i;
          o_br_sel  = br_jalr;
          o_alu_op  = alu_add;    // target = rs1 + imm
          o_opa_sel = opa_rf;
          o_opb_sel = opb_imm;
          o_wb_sel  = wb_pc;
        end else begin
          o_illegal = 1'b1;
        end
      end
      opc_load, opc_store: begin
        if ((opcode == opc_load && funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu}) ||
            (opcode == opc_store && funct3 inside {f3_sb, f3_sh, f3_sw})) begin
          o_fmt       = (opcode == opc_load) ? fmt_i : fmt_s;
          o_alu_op    = alu_add;  // address = rs1 + imm
          o_opa_sel   = opa_rf;
          o_opb_sel   = opb_imm;
          o_be_sel    = (funct3[1:0] == 2'b00) ? be_byte :
                        (funct3[1:0] == 2'b01) ? be_half : be_word;
          o_dmem_sext = ~funct3[2]; // lbu and lhu zero-extend
          o_dmem_rd   = (opcode == opc_load);
          o_dmem_wr   = (opcode == opc_store);
          o_rs2_used  = (opcode == opc_store);
          o_wb_sel    = (opcode == opc_load) ? wb_dmem : wb_none;
        end else begin
          o_illegal = 1'b1;
        end
      end
      default: o_illegal = 1'b1;
    endcase
  end

  assign o_en_wb       = (o_wb_sel != wb_none);
  assign o_cond_branch = o_br_sel inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
  assign o_jump_reg    = (o_br_sel == br_jalr);

  // a trapped encoding must not touch memory or the register file
  a_illegal_inert: assert final (!o_illegal || !(o_en_wb || o_dmem_rd || o_dmem_wr));

endmodule

`default_nettype wire

// File: logic/rv_imm_gen.sv
//****************************************************************************
// Immediate generator. Gathers the immediate bits for the decoded format
// and sign-extends from instruction bit 31.
//****************************************************************************
`default_nettype none

module rv_imm_gen (
  input  wire rv_decode_pkg::instr_t     i_instr,
  input  wire rv_decode_pkg::instr_fmt_e i_fmt,
  output rv_decode_pkg::word_t           o_imm
);
  import rv_decode_pkg::*;

  logic sign;

  assign sign = i_instr[31];

  always_comb begin
    case (i_fmt)
      fmt_i: o_imm = {{20{sign}}, i_instr[31:20]};
      fmt_s: o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
      fmt_b: begin
        o_imm = {{19{sign}}, i_instr[31], i_instr[7], i_instr[30:25],
                 i_instr[11:8], 1'b0};          // halfword aligned
      end
      fmt_u: o_imm = {i_instr[31:12], 12'b0};   // upper 20 bits, low bits zero
      fmt_j: begin
        o_imm = {{11{sign}}, i_instr[31], i_instr[19:12], i_instr[20],
                 i_instr[30:21], 1'b0};
      end
      default: o_imm = '0;                      // r format carries none
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_decode_reg.sv
//****************************************************************************
// Output register of the decode stage with a valid/ready handshake.
// Loads one record per accept and holds it while the consumer stalls.
//****************************************************************************
`default_nettype none

module rv_decode_reg (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire                         i_valid,
  output logic                        o_ready,
  input  wire rv_decode_pkg::instr_t  i_instr,
  input  wire rv_decode_pkg::word_t   i_imm,
  input  wire rv_decode_pkg::alu_op_e i_alu_op,
  input  wire rv_decode_pkg::opa_sel_e i_opa_sel,
  input  wire rv_decode_pkg::opb_sel_e i_opb_sel,
  input  wire rv_decode_pkg::br_sel_e i_br_sel,
  input  wire rv_decode_pkg::wb_sel_e i_wb_sel,
  input  wire rv_decode_pkg::be_sel_e i_be_sel,
  input  wire                         i_rs2_used,
  input  wire                         i_dmem_rd,
  input  wire                         i_dmem_wr,
  input  wire                         i_dmem_sext,
  input  wire                         i_en_wb,
  input  wire                         i_cond_branch,
  input  wire                         i_jump_reg,
  input  wire                         i_illegal,
  output logic                        o_valid,
  input  wire                         i_ready,
  output rv_decode_pkg::reg_addr_t    o_rd,
  output rv_decode_pkg::reg_addr_t    o_rs1,
  output rv_decode_pkg::reg_addr_t    o_rs2,
  output rv_decode_pkg::word_t        o_imm,
  output rv_decode_pkg::alu_op_e      o_alu_op,
  output rv_decode_pkg::opa_sel_e     o_opa_sel,
  output rv_decode_pkg::opb_sel_e     o_opb_sel,
  output rv_decode_pkg::br_sel_e      o_br_sel,
  output rv_decode_pkg::wb_sel_e      o_wb_sel,
  output rv_decode_pkg::be_sel_e      o_be_sel,
  output logic                        o_rs2_used,
  output logic                        o_dmem_rd,
  output logic                        o_dmem_wr,
  output logic                        o_dmem_sext,
  output logic                        o_en_wb,
  output logic                        o_cond_branch,
  output logic                        o_jump_reg,
  output logic                        o_illegal
);
  import rv_decode_pkg::*;

  logic accept;

  assign o_ready = ~o_valid | i_ready;  // empty, or drained this cycle
  assign accept  = i_valid & o_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid       <= 1'b0;
      o_rd          <= '0;
      o_rs1         <= '0;
      o_rs2         <= '0;
      o_imm         <= '0;
      o_alu_op      <= alu_nop;
      o_opa_sel     <= opa_none;
      o_opb_sel     <= opb_none;
      o_br_sel      <= br_none;
      o_wb_sel      <= wb_none;
      o_be_sel      <= be_none;
      o_rs2_used    <= 1'b0;
      o_dmem_rd     <= 1'b0;
      o_dmem_wr     <= 1'b0;
      o_dmem_sext   <= 1'b0;
      o_en_wb       <= 1'b0;
      o_cond_branch <= 1'b0;
      o_jump_reg    <= 1'b0;
      o_illegal     <= 1'b0;
    end else begin
      if (o_ready) begin
        o_valid <= i_valid;              // refill or go empty
      end
      if (accept) begin
        o_rd          <= i_instr[11:7];
        o_rs1         <= i_instr[19:15];
        o_rs2         <= i_instr[24:20];
        o_imm         <= i_imm;
        o_alu_op      <= i_alu_op;
        o_opa_sel     <= i_opa_sel;
        o_opb_sel     <= i_opb_sel;
        o_br_sel      <= i_br_sel;
        o_wb_sel      <= i_wb_sel;
        o_be_sel      <= i_be_sel;
        o_rs2_used    <= i_rs2_used;
        o_dmem_rd     <= i_dmem_rd;
        o_dmem_wr     <= i_dmem_wr;
        o_dmem_sext   <= i_dmem_sext;
        o_en_wb       <= i_en_wb;
        o_cond_branch <= i_cond_branch;
        o_jump_reg    <= i_jump_reg;
        o_illegal     <= i_illegal;
      end
    end
  end

  // a stalled record stays put until the consumer takes it
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable({o_rd, o_rs1, o_rs2, o_imm, o_alu_op,
      o_opa_sel, o_opb_sel, o_br_sel, o_wb_sel, o_be_sel, o_rs2_used, o_dmem_rd,
      o_dmem_wr, o_dmem_sext, o_en_wb, o_cond_branch, o_jump_reg, o_illegal}));

  a_empty_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_valid);

endmodule

`default_nettype wire

// File: logic/rv_decode_top.sv
//****************************************************************************
// RV32I decode stage. Decoder and immediate generator feed the output
// register, so a record appears one cycle after its instruction is accepted.
//****************************************************************************
`default_nettype none

module rv_decode_top (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_valid,
  output logic                       o_ready,
  input  wire rv_decode_pkg::instr_t i_instr,
  output logic                       o_valid,
  input  wire                        i_ready,
  output rv_decode_pkg::reg_addr_t   o_rd,
  output rv_decode_pkg::reg_addr_t   o_rs1,
  output rv_decode_pkg::reg_addr_t   o_rs2,
  output rv_decode_pkg::word_t       o_imm,
  output rv_decode_pkg::alu_op_e     o_alu_op,
  output rv_decode_pkg::opa_sel_e    o_opa_sel,
  output rv_decode_pkg::opb_sel_e    o_opb_sel,
  output rv_decode_pkg::br_sel_e     o_br_sel,
  output rv_decode_pkg::wb_sel_e     o_wb_sel,
  output rv_decode_pkg::be_sel_e     o_be_sel,
  output logic                       o_rs2_used,
  output logic                       o_dmem_rd,
  output logic                       o_dmem_wr,
  output logic                       o_dmem_sext,
  output logic                       o_en_wb,
  output logic                       o_cond_branch,
  output logic                       o_jump_reg,
  output logic                       o_illegal
);
  import rv_decode_pkg::*;

  instr_fmt_e dec_fmt;
  alu_op_e    dec_alu_op;
  opa_sel_e   dec_opa_sel;
  opb_sel_e   dec_opb_sel;
  br_sel_e    dec_br_sel;
  wb_sel_e    dec_wb_sel;
  be_sel_e    dec_be_sel;
  logic       dec_rs2_used;
  logic       dec_dmem_rd;
  logic       dec_dmem_wr;
  logic       dec_dmem_sext;
  logic       dec_en_wb;
  logic       dec_cond_branch;
  logic       dec_jump_reg;
  logic       dec_illegal;
  word_t      dec_imm;

  rv_opcode_decoder u_decoder (
    .i_instr       (i_instr),
    .o_fmt         (dec_fmt),
    .o_alu_op      (dec_alu_op),
    .o_opa_sel     (dec_opa_sel),
    .o_opb_sel     (dec_opb_sel),
    .o_br_sel      (dec_br_sel),
    .o_wb_sel      (dec_wb_sel),
    .o_be_sel      (dec_be_sel),
    .o_rs2_used    (dec_rs2_used),
    .o_dmem_rd     (dec_dmem_rd),
    .o_dmem_wr     (dec_dmem_wr),
    .o_dmem_sext   (dec_dmem_sext),
    .o_en_wb       (dec_en_wb),
    .o_cond_branch (dec_cond_branch),
    .o_jump_reg    (dec_jump_reg),
    .o_illegal     (dec_illegal)
  );

  rv_imm_gen u_imm_gen (
    .i_instr (i_instr),
    .i_fmt   (dec_fmt),
    .o_imm   (dec_imm)
  );

  // handshake and record outputs share names with the top ports
  rv_decode_reg u_out_reg (
    .i_imm         (dec_imm),
    .i_alu_op      (dec_alu_op),
    .i_opa_sel     (dec_opa_sel),
    .i_opb_sel     (dec_opb_sel),
    .i_br_sel      (dec_br_sel),
    .i_wb_sel      (dec_wb_sel),
    .i_be_sel      (dec_be_sel),
    .i_rs2_used    (dec_rs2_used),
    .i_dmem_rd     (dec_dmem_rd),
    .i_dmem_wr     (dec_dmem_wr),
    .i_dmem_sext   (dec_dmem_sext),
    .i_en_wb       (dec_en_wb),
    .i_cond_branch (dec_cond_branch),
    .i_jump_reg    (dec_jump_reg),
    .i_illegal     (dec_illegal),
    .*
  );

endmodule

`default_nettype wire

// File: bench/rv_decode_ref.svh
//****************************************************************************
// Reference model of the RV32I decode rules and the record type it fills.
// Included inside the testbench module, after the package import.
//****************************************************************************
`ifndef RV_DECODE_REF_SVH
`define RV_DECODE_REF_SVH

typedef struct packed {
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm;
  alu_op_e   alu_op;
  opa_sel_e  opa_sel;
  opb_sel_e  opb_sel;
  br_sel_e   br_sel;
  wb_sel_e   wb_sel;
  be_sel_e   be_sel;
  logic      rs2_used;
  logic      dmem_rd;
  logic      dmem_wr;
  logic      dmem_sext;
  logic      en_wb;
  logic      cond_branch;
  logic      jump_reg;
  logic      illegal;
} dec_rec_t;

// field of width bits sits in the low bits of v
function automatic word_t sign_extend(input logic [31:0] v, input int unsigned bits);
  return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
endfunction

function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic alt);
  case (f3)
    3'b000:  return alt ? alu_sub : alu_add;
    3'b001:  return alu_sll;
    3'b010:  return alu_slt;
    3'b011:  return alu_sltu;
    3'b100:  return alu_xor;
    3'b101:  return alt ? alu_sra : alu_srl;
    3'b110:  return alu_or;
    default: return alu_and;
  endcase
endfunction

function automatic be_sel_e access_size_for(input logic [2:0] f3);
  case (f3[1:0])
    2'b00:   return be_byte;
    2'b01:   return be_half;
    default: return be_word;
  endcase
endfunction

function automatic dec_rec_t rv_decode_ref(input instr_t ins);
  dec_rec_t   r;
  instr_fmt_e fmt;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  opc = ins[6:0];
  f3  = ins[14:12];
  f7  = ins[31:25];
  fmt = fmt_r;
  r.rd        = ins[11:7];   // register fields always sliced
  r.rs1       = ins[19:15];
  r.rs2       = ins[24:20];
  r.alu_op    = alu_nop;
  r.opa_sel   = opa_none;
  r.opb_sel   = opb_none;
  r.br_sel    = br_none;
  r.wb_sel    = wb_none;
  r.be_sel    = be_none;
  r.rs2_used  = 1'b0;
  r.dmem_rd   = 1'b0;
  r.dmem_wr   = 1'b0;
  r.dmem_sext = 1'b0;
  r.illegal   = 1'b0;
  if (opc == opc_op) begin
    if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
      r.alu_op   = alu_op_for(f3, f7[5]);
      r.opa_sel  = opa_rf;
      r.opb_sel  = opb_rf;
      r.wb_sel   = wb_alu;
      r.rs2_used = 1'b1;
    end else begin
      r.illegal = 1'b1;
    end
  end else if (opc == opc_op_imm) begin
    if ((f3 == 3'b001 && f7 != 7'h00) ||
        (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)) begin
      r.illegal = 1'b1;   // shift amount field with a bad funct7
    end else begin
      fmt       = fmt_i;
      r.alu_op  = alu_op_for(f3, f3 == 3'b101 && f7[5]);
      r.opa_sel = opa_rf;
      r.opb_sel = opb_imm;
      r.wb_sel  = wb_alu;
    end
  end else if (opc == opc_lui || opc == opc_auipc) begin
    fmt       = fmt_u;
    r.alu_op  = (opc == opc_lui) ? alu_cpb : alu_add;
    r.opa_sel = (opc == opc_lui) ? opa_rf : opa_pc;
    r.opb_sel = opb_imm;
    r.wb_sel  = wb_alu;
  end else if (opc == opc_branch) begin
    if (f3 == 3'b010 || f3 == 3'b011) begin
      r.illegal = 1'b1;
    end else begin
      fmt        = fmt_b;
      r.alu_op   = alu_add;
      r.opa_sel  = opa_rf;
      r.opb_sel  = opb_rf;
      r.rs2_used = 1'b1;
      case (f3)
        3'b000:  r.br_sel = br_beq;
        3'b001:  r.br_sel = br_bne;
        3'b100:  r.br_sel = br_blt;
        3'b101:  r.br_sel = br_bge;
        3'b110:  r.br_sel = br_bltu;
        default: r.br_sel = br_bgeu;
      endcase
    end
  end else if (opc == opc_jal) begin
    fmt      = fmt_j;
    r.br_sel = br_jal;
    r.wb_sel = wb_pc;
  end else if (opc == opc_jalr && f3 == 3'b000) begin
    fmt       = fmt_i;
    r.br_sel  = br_jalr;
    r.alu_op  = alu_add;
    r.opa_sel = opa_rf;
    r.opb_sel = opb_imm;
    r.wb_sel  = wb_pc;
  end else if (opc == opc_load && !(f3 == 3'b011 || f3[2:1] == 2'b11)) begin
    fmt         = fmt_i;
    r.alu_op    = alu_add;
    r.opa_sel   = opa_rf;
    r.opb_sel   = opb_imm;
    r.wb_sel    = wb_dmem;
    r.dmem_rd   = 1'b1;
    r.dmem_sext = !f3[2];   // lbu, lhu zero-extend
    r.be_sel    = access_size_for(f3);
  end else if (opc == opc_store && f3 <= 3'b010) begin
    fmt         = fmt_s;
    r.alu_op    = alu_add;
    r.opa_sel   = opa_rf;
    r.opb_sel   = opb_imm;
    r.dmem_wr   = 1'b1;
    r.rs2_used  = 1'b1;
    r.dmem_sext = 1'b1;
    r.be_sel    = access_size_for(f3);
  end else begin
    r.illegal = 1'b1;     // unused opcode or bad jalr/load/store funct3
  end
  r.en_wb       = (r.wb_sel != wb_none);
  r.cond_branch = (r.br_sel != br_none) && (r.br_sel != br_jal) && (r.br_sel != br_jalr);
  r.jump_reg    = (r.br_sel == br_jalr);
  case (fmt)
    fmt_i:   r.imm = sign_extend(ins[31:20], 12);
    fmt_s:   r.imm = sign_extend({ins[31:25], ins[11:7]}, 12);
    fmt_b:   r.imm = sign_extend({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
    fmt_u:   r.imm = {ins[31:12], 12'h000};
    fmt_j:   r.imm = sign_extend({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
    default: r.imm = '0;
  endcase
  return r;
endfunction

`endif

// File: bench/rv_decode_tb.sv
//****************************************************************************
// Testbench for the decode stage. Sends directed, illegal and random words
// through the handshake, with and without back-pressure, and checks each
// record in order against the reference decode model.
//****************************************************************************
`default_nettype none

module rv_decode_tb;
  import rv_decode_pkg::*;

  `include "rv_decode_ref.svh"

  logic      i_clk;
  logic      i_rst;
  logic      i_valid;
  logic      o_ready;
  instr_t    i_instr;
  logic      o_valid;
  logic      i_ready;
  reg_addr_t o_rd;
  reg_addr_t o_rs1;
  reg_addr_t o_rs2;
  word_t     o_imm;
  alu_op_e   o_alu_op;
  opa_sel_e  o_opa_sel;
  opb_sel_e  o_opb_sel;
  br_sel_e   o_br_sel;
  wb_sel_e   o_wb_sel;
  be_sel_e   o_be_sel;
  logic      o_rs2_used;
  logic      o_dmem_rd;
  logic      o_dmem_wr;
  logic      o_dmem_sext;
  logic      o_en_wb;
  logic      o_cond_branch;
  logic      o_jump_reg;
  logic      o_illegal;

  dec_rec_t  exp_q[$];      // expected records, oldest first
  string     name_q[$];
  dec_rec_t  held;
  logic      stalled = 1'b0;
  logic      bp_en;
  logic      timed_out;
  int        checks;
  int        mismatches;
  int        other_errors;
  int        sent;
  int        received;

  rv_decode_top i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic dec_rec_t dut_record();
    dec_rec_t r;
    r = {o_rd, o_rs1, o_rs2, o_imm, o_alu_op, o_opa_sel, o_opb_sel, o_br_sel,
         o_wb_sel, o_be_sel, o_rs2_used, o_dmem_rd, o_dmem_wr, o_dmem_sext,
         o_en_wb, o_cond_branch, o_jump_reg, o_illegal};
    return r;
  endfunction

  function automatic instr_t random_legal_instr();
    instr_t w;
    w = $urandom;
    case ($urandom % 9)
      0: begin
        w[6:0]   = opc_op;
        w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[30]) ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = opc_op_imm;
        if (w[14:12] == 3'b001) w[31:25] = 7'h00;
        if (w[14:12] == 3'b101) w[31:25] = w[30] ? 7'h20 : 7'h00;
      end
      2: w[6:0] = opc_lui;
      3: w[6:0] = opc_auipc;
      4: begin
        w[6:0] = opc_branch;
        if (w[14:13] == 2'b01) w[14] = 1'b1;   // skip the two unused compares
      end
      5: w[6:0] = opc_jal;
      6: begin
        w[6:0]   = opc_jalr;
        w[14:12] = 3'b000;
      end
      7: begin
        w[6:0] = opc_load;
        if (w[13] && (w[12] || w[14])) w[14:12] = 3'b010;
      end
      default: begin
        w[6:0] = opc_store;
        w[14]  = 1'b0;
        if (w[13:12] == 2'b11) w[12] = 1'b0;
      end
    endcase
    return w;
  endfunction

  task automatic check_field(input string test, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      mismatches++;
      $display("Mismatch test=%s field=%s expected=%h actual=%h", test, field, exp, act);
    end
  endtask

  task automatic compare_record(input string test, input dec_rec_t exp, input dec_rec_t act);
    check_field(test, "rd", exp.rd, act.rd);
    check_field(test, "rs1", exp.rs1, act.rs1);
    check_field(test, "rs2", exp.rs2, act.rs2);
    check_field(test, "imm", exp.imm, act.imm);
    check_field(test, "alu_op", exp.alu_op, act.alu_op);
    check_field(test, "opa_sel", exp.opa_sel, act.opa_sel);
    check_field(test, "opb_sel", exp.opb_sel, act.opb_sel);
    check_field(test, "br_sel", exp.br_sel, act.br_sel);
    check_field(test, "wb_sel", exp.wb_sel, act.wb_sel);
    check_field(test, "be_sel", exp.be_sel, act.be_sel);
    check_field(test, "rs2_used", exp.rs2_used, act.rs2_used);
    check_field(test, "dmem_rd", exp.dmem_rd, act.dmem_rd);
    check_field(test, "dmem_wr", exp.dmem_wr, act.dmem_wr);
    check_field(test, "dmem_sext", exp.dmem_sext, act.dmem_sext);
    check_field(test, "en_wb", exp.en_wb, act.en_wb);
    check_field(test, "cond_branch", exp.cond_branch, act.cond_branch);
    check_field(test, "jump_reg", exp.jump_reg, act.jump_reg);
    check_field(test, "illegal", exp.illegal, act.illegal);
    assert (!(act.illegal && (act.en_wb || act.dmem_rd || act.dmem_wr))) else begin
      other_errors++;
      $display("%s: illegal record still requests write-back or memory access", test);
    end
  endtask

  // holds the word until accepted, called on a falling edge
  task automatic send_instr(input string name, input instr_t ins);
    int waited;
    if (timed_out) return;
    i_valid = 1'b1;
    i_instr = ins;
    waited  = 0;
    @(posedge i_clk);
    while (!o_ready && waited < 200) begin
      @(posedge i_clk);
      waited++;
    end
    if (!o_ready) begin
      other_errors++;
      timed_out = 1'b1;
      $display("timeout: instruction of test %s was never accepted", name);
      @(negedge i_clk);
    end else begin
      exp_q.push_back(rv_decode_ref(ins));
      name_q.push_back(name);
      sent++;
      @(negedge i_clk);
      assert (o_valid) else begin
        other_errors++;
        $display("no valid record one cycle after test %s was accepted", name);
      end
    end
    i_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    i_valid = 1'b0;
    i_instr = $urandom;       // ignored while not valid
    repeat (n) @(negedge i_clk);
  endtask

  task automatic random_traffic(input string name, input int count);
    repeat (count) begin
      idle_cycles(($urandom % 4 == 0) ? 1 + $urandom % 2 : 0);
      send_instr(name, ($urandom % 2) ? random_legal_instr() : instr_t'($urandom));
    end
  endtask

  always @(posedge i_clk) begin : compare
    dec_rec_t act;
    act = dut_record();
    if (!i_rst) begin
      if (stalled) begin
        assert (o_valid && act == held) else begin
          other_errors++;
          $display("stalled record changed or vanished before it was consumed");
        end
      end
      if (o_valid && i_ready) begin
        received++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("output transfer with no accepted instruction behind it");
        end else begin
          compare_record(name_q.pop_front(), exp_q.pop_front(), act);
        end
      end
      stalled = o_valid && !i_ready;
      held    = act;
    end
  end

  // random consumer stalls while back-pressure is on
  initial begin
    forever begin
      @(negedge i_clk);
      if (bp_en) i_ready = ($urandom % 4) != 0;
    end
  end

  initial begin : stimulus
    int waited;
    void'($urandom(32'h06fa_21af));
    i_rst        = 1'b1;
    i_valid      = 1'b0;
    i_instr      = '0;
    i_ready      = 1'b0;     // so o_ready after reset comes from the empty register
    bp_en        = 1'b0;
    timed_out    = 1'b0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    sent         = 0;
    received     = 0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    checks++;
    assert (!o_valid && o_ready) else begin
      other_errors++;
      $display("after reset the stage is not empty and ready");
    end
    i_ready = 1'b1;

    send_instr("add", {7'h00, 5'd3, 5'd2, 3'b000, 5'd1, opc_op});
    send_instr("sub", {7'h20, 5'd7, 5'd6, 3'b000, 5'd5, opc_op});
    send_instr("sra", {7'h20, 5'd10, 5'd9, 3'b101, 5'd8, opc_op});
    send_instr("addi_neg", {12'hffb, 5'd2, 3'b000, 5'd1, opc_op_imm});
    send_instr("srai", {7'h20, 5'd7, 5'd4, 3'b101, 5'd3, opc_op_imm});
    send_instr("nop", 32'h0000_0013);
    send_instr("lui", {20'hdeadb, 5'd10, opc_lui});
    send_instr("auipc", {20'h80001, 5'd11, opc_auipc});
    send_instr("beq_neg", {1'b1, 6'h3f, 5'd2, 5'd1, 3'b000, 4'b1100, 1'b1, opc_branch});
    send_instr("bgeu", {1'b0, 6'h00, 5'd4, 5'd3, 3'b111, 4'b1000, 1'b0, opc_branch});
    send_instr("jal_neg", {1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, opc_jal});
    send_instr("jalr", {12'hffc, 5'd5, 3'b000, 5'd1, opc_jalr});
    send_instr("lb_neg", {12'hfff, 5'd3, 3'b000, 5'd2, opc_load});
    send_instr("lhu", {12'h008, 5'd5, 3'b101, 5'd4, opc_load});
    send_instr("lw", {12'h7ff, 5'd6, 3'b010, 5'd7, opc_load});
    send_instr("sb_neg", {7'h7f, 5'd8, 5'd9, 3'b000, 5'h10, opc_store});
    send_instr("sw", {7'h01, 5'd10, 5'd11, 3'b010, 5'h04, opc_store});

    send_instr("bad_opcode", 32'h0000_007f);
    send_instr("custom0", 32'h0000_000b);
    send_instr("ecall", 32'h0000_0073);
    send_instr("mul", {7'h01, 5'd2, 5'd1, 3'b000, 5'd3, opc_op});
    send_instr("sll_alt", {7'h20, 5'd2, 5'd1, 3'b001, 5'd3, opc_op});
    send_instr("srai_bad", {7'h40, 5'd3, 5'd1, 3'b101, 5'd2, opc_op_imm});
    send_instr("branch_010", {7'h00, 5'd2, 5'd1, 3'b010, 5'd0, opc_branch});
    send_instr("load_011", {12'h010, 5'd1, 3'b011, 5'd2, opc_load});

    random_traffic("random", 300);
    bp_en = 1'b1;
    random_traffic("backpressure", 400);
    bp_en   = 1'b0;
    i_ready = 1'b1;
    idle_cycles(0);

    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      @(negedge i_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("timeout: %0d accepted records never came out", exp_q.size());
    end
    repeat (4) @(negedge i_clk);  // catch any extra output transfer
    assert (sent == received) else begin
      other_errors++;
      $display("accepted %0d instructions but saw %0d records", sent, received);
    end

    $display("summary: %0d checks, %0d mismatches, %0d other errors, %0d records",
             checks, mismatches, other_errors, received);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_decode.f
+incdir+bench
logic/rv_decode_pkg.sv
logic/rv_opcode_decoder.sv
logic/rv_imm_gen.sv
logic/rv_decode_reg.sv
logic/rv_decode_top.sv
bench/rv_decode_tb.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - logic/rv_decode_pkg.sv
  - logic/rv_opcode_decoder.sv
  - logic/rv_imm_gen.sv
  - logic/rv_decode_reg.sv
  - logic/rv_decode_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rv_decode_tb.sv
